// File: src.f
+incdir+tests
hdl/csr_pkg.sv
hdl/csr_addr_decode.sv
hdl/csr_exception_regs.sv
hdl/csr_timer.sv
hdl/csr_scratch_regs.sv
hdl/csr_read_mux.sv
hdl/csr_top.sv
tests/tb_csr.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the CSR testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_csr -o sim_csr
./obj_dir/sim_csr | tee sim.log

if grep -q "TEST PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: tests/csr_model.svh
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// expected register value after a masked write
function automatic csr_pkg::csr_data_t apply_mask(input csr_pkg::csr_data_t old_val,
                                                  input csr_pkg::csr_data_t wdata,
                                                  input csr_pkg::csr_data_t mask);
    return (old_val & ~mask) | (wdata & mask);
endfunction

// exception entry clears plv and ie
function automatic csr_pkg::csr_data_t crmd_after_flush(input csr_pkg::csr_data_t crmd);
    return crmd & ~32'h7;
endfunction

// old plv and ie saved into prmd
function automatic csr_pkg::csr_data_t prmd_after_flush(input csr_pkg::csr_data_t prmd,
                                                        input csr_pkg::csr_data_t crmd);
    return (prmd & ~32'h7) | (crmd & 32'h7);
endfunction

function automatic csr_pkg::csr_data_t crmd_after_ertn(input csr_pkg::csr_data_t crmd,
                                                       input csr_pkg::csr_data_t prmd);
    return (crmd & ~32'h7) | (prmd & 32'h7);
endfunction

// ecode at 21:16, esubcode at 30:22
function automatic csr_pkg::csr_data_t estat_after_flush(input csr_pkg::csr_data_t estat,
                                                         input csr_pkg::ecode_t ecode,
                                                         input csr_pkg::esubcode_t esub);
    return (estat & ~32'h7fff_0000) | {1'b0, esub, ecode, 16'h0};
endfunction

function automatic int expiry_cycles(input int n);
    return 4 * n + 1;
endfunction

function automatic csr_pkg::csr_data_t timer_next_tval(input csr_pkg::csr_data_t tval,
                                                       input csr_pkg::csr_data_t tcfg);
    if (tval != 0) begin
        return tval - 32'd1;
    end
    if (tcfg[1]) begin
        return {tcfg[31:2], 2'b00};
    end
    return 32'hffff_ffff;
endfunction

function automatic logic timer_keeps_counting(input csr_pkg::csr_data_t tval,
                                              input csr_pkg::csr_data_t tcfg);
    return (tval != 0) || tcfg[1];
endfunction

function automatic logic int_pending(input csr_pkg::csr_data_t ecfg,
                                     input csr_pkg::csr_data_t estat,
                                     input logic ie);
    return ((ecfg[12:0] & estat[12:0]) != 13'h0) && ie;
endfunction

`endif

// File: tests/tb_csr.sv
`timescale 1ns/1ps

module tb_csr;

    `include "csr_model.svh"

    localparam int N_ITER      = 12;
    localparam int N_MAX       = 8;
    // summed cycles of the task bodies below
    localparam int TEST_CYCLES = 6 * N_ITER + 4 * N_ITER + 4 + 14 * N_ITER
                                 + 2 * (4 * N_MAX + 1) + 3 * (4 * N_MAX + 1) + 60
                                 + 10 * N_ITER;
    localparam int TIMEOUT     = 2 * TEST_CYCLES + 10;

    logic        clk;
    logic        reset;
    logic [13:0] csr_raddr;
    logic [31:0] csr_rdata;
    logic        csr_wr_en;
    logic [13:0] csr_waddr;
    logic [31:0] csr_wdata;
    logic        excp_flush;
    logic [31:0] era_in;
    logic [5:0]  ecode_in;
    logic [8:0]  esubcode_in;
    logic        ertn_flush;
    logic [7:0]  interrupt;
    logic [31:0] eentry_out;
    logic [31:0] era_out;
    logic [1:0]  plv_out;
    logic [31:0] tid_out;
    logic        has_int;

    integer seed = 85264;
    int     errors = 0;
    int     checks = 0;
    int     test_errors;
    int     test_checks;
    int     cycle_count = 0;

    // shadow state of the register file
    logic [31:0] m_crmd = 32'h8;
    logic [31:0] m_prmd = '0;
    logic [31:0] m_ecfg = '0;
    logic [31:0] m_estat = '0;
    logic [31:0] m_era = '0;
    logic [31:0] m_eentry = '0;
    logic [31:0] m_scratch [5];
    logic [7:0]  m_hw = '0;
    logic        m_pend = 1'b0;

    csr_top u_csr_top (
        .clk         (clk),
        .reset       (reset),
        .csr_raddr   (csr_raddr),
        .csr_rdata   (csr_rdata),
        .csr_wr_en   (csr_wr_en),
        .csr_waddr   (csr_waddr),
        .csr_wdata   (csr_wdata),
        .excp_flush  (excp_flush),
        .era_in      (era_in),
        .ecode_in    (ecode_in),
        .esubcode_in (esubcode_in),
        .ertn_flush  (ertn_flush),
        .interrupt   (interrupt),
        .eentry_out  (eentry_out),
        .era_out     (era_out),
        .plv_out     (plv_out),
        .tid_out     (tid_out),
        .has_int     (has_int)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] rand32();
        rand32 = $random(seed);
    endfunction

    // expected ESTAT with hw lines and timer bit
    function automatic logic [31:0] estat_view();
        return m_estat | {20'h0, m_pend, 1'b0, m_hw, 2'b00};
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic start_test();
        test_errors = errors;
        test_checks = checks;
    endtask

    task automatic end_test(input string name);
        $display("%-16s %0d checks, %0d errors", name, checks - test_checks,
                 errors - test_errors);
    endtask

    // write lands on the second edge where the task returns
    task automatic write_csr(input logic [13:0] addr, input logic [31:0] data);
        @(posedge clk);
        csr_wr_en <= 1'b1;
        csr_waddr <= addr;
        csr_wdata <= data;
        @(posedge clk);
        csr_wr_en <= 1'b0;
    endtask

    task automatic read_check(input logic [13:0] addr, input logic [31:0] exp,
                              input string name);
        @(posedge clk);
        csr_raddr <= addr;
        @(negedge clk);
        compare(name, exp, csr_rdata);
    endtask

    task automatic scratch_test();
        logic [13:0] addr;
        logic [31:0] data;
        int          idx;
        start_test();
        for (int i = 0; i < N_ITER; i++) begin
            idx = rand32() % 5;
            addr = (idx == 4) ? csr_pkg::ADDR_TID : csr_pkg::ADDR_SAVE0 + 14'(idx);
            data = rand32();
            write_csr(addr, data);
            m_scratch[idx] = data;
            read_check(addr, data, "csr_rdata");
            compare("tid_out", m_scratch[4], tid_out);
            // same-cycle bypass
            data = rand32();
            @(posedge clk);
            csr_wr_en <= 1'b1;
            csr_waddr <= addr;
            csr_wdata <= data;
            csr_raddr <= addr;
            @(negedge clk);
            compare("csr_rdata", data, csr_rdata);
            @(posedge clk);
            csr_wr_en <= 1'b0;
            m_scratch[idx] = data;
        end
        end_test("scratch");
    endtask

    task automatic mask_test();
        logic [31:0] data;
        int          idx;
        start_test();
        for (int i = 0; i < N_ITER; i++) begin
            idx = rand32() % 5;
            data = rand32();
            case (idx)
                0: begin
                    write_csr(csr_pkg::ADDR_CRMD, data);
                    m_crmd = apply_mask(m_crmd, data, csr_pkg::MASK_CRMD);
                    read_check(csr_pkg::ADDR_CRMD, m_crmd, "csr_rdata");
                    compare("plv_out", {30'h0, m_crmd[1:0]}, {30'h0, plv_out});
                end
                1: begin
                    write_csr(csr_pkg::ADDR_PRMD, data);
                    m_prmd = apply_mask(m_prmd, data, csr_pkg::MASK_PRMD);
                    read_check(csr_pkg::ADDR_PRMD, m_prmd, "csr_rdata");
                end
                2: begin
                    write_csr(csr_pkg::ADDR_ECFG, data);
                    m_ecfg = apply_mask(m_ecfg, data, csr_pkg::MASK_ECFG);
                    read_check(csr_pkg::ADDR_ECFG, m_ecfg, "csr_rdata");
                end
                3: begin
                    write_csr(csr_pkg::ADDR_ESTAT, data);
                    m_estat = apply_mask(m_estat, data, csr_pkg::MASK_ESTAT_SW);
                    read_check(csr_pkg::ADDR_ESTAT, estat_view(), "csr_rdata");
                end
                default: begin
                    write_csr(csr_pkg::ADDR_EENTRY, data);
                    m_eentry = apply_mask(m_eentry, data, csr_pkg::MASK_EENTRY);
                    read_check(csr_pkg::ADDR_EENTRY, m_eentry, "csr_rdata");
                    compare("eentry_out", m_eentry, eentry_out);
                end
            endcase
        end
        data = rand32();
        read_check(14'h100 | {6'h0, data[7:0]}, 32'h0, "csr_rdata");
        end_test("write_mask");
    endtask

    task automatic exception_test();
        logic [31:0] r;
        start_test();
        for (int i = 0; i < N_ITER; i++) begin
            r = rand32();
            write_csr(csr_pkg::ADDR_CRMD, 32'h8 | {29'h0, r[2:0]});
            m_crmd = apply_mask(m_crmd, 32'h8 | {29'h0, r[2:0]}, csr_pkg::MASK_CRMD);
            r = rand32();
            @(posedge clk);
            excp_flush  <= 1'b1;
            era_in      <= rand32();
            ecode_in    <= r[5:0];
            esubcode_in <= r[14:6];
            @(posedge clk);
            excp_flush <= 1'b0;
            m_prmd  = prmd_after_flush(m_prmd, m_crmd);
            m_crmd  = crmd_after_flush(m_crmd);
            m_era   = era_in;
            m_estat = estat_after_flush(m_estat, r[5:0], r[14:6]);
            @(negedge clk);
            compare("plv_out", {30'h0, m_crmd[1:0]}, {30'h0, plv_out});
            compare("era_out", m_era, era_out);
            read_check(csr_pkg::ADDR_CRMD, m_crmd, "csr_rdata");
            read_check(csr_pkg::ADDR_PRMD, m_prmd, "csr_rdata");
            read_check(csr_pkg::ADDR_ESTAT, estat_view(), "csr_rdata");
            @(posedge clk);
            ertn_flush <= 1'b1;
            @(posedge clk);
            ertn_flush <= 1'b0;
            m_crmd = crmd_after_ertn(m_crmd, m_prmd);
            @(negedge clk);
            compare("plv_out", {30'h0, m_crmd[1:0]}, {30'h0, plv_out});
            read_check(csr_pkg::ADDR_CRMD, m_crmd, "csr_rdata");
        end
        end_test("exception");
    endtask

    // one model step per edge from the TCFG write edge
    task automatic timer_test(input logic periodic, input int n, input int cycles);
        logic [31:0] tcfg;
        logic [31:0] m_tval;
        logic        m_count;
        logic        expire;
        logic        clr;
        int          pend_age;
        int          first_set;
        tcfg = {n[29:0], periodic, 1'b1};
        write_csr(csr_pkg::ADDR_TCFG, tcfg);
        csr_raddr <= csr_pkg::ADDR_TVAL;
        m_tval = {tcfg[31:2], 2'b00};
        m_count = 1'b1;
        clr = 1'b0;
        pend_age = 0;
        first_set = -1;
        for (int k = 0; k < cycles; k++) begin
            @(negedge clk);
            compare("csr_rdata", m_tval, csr_rdata);
            compare("has_int", {31'h0, m_pend}, {31'h0, has_int});
            // first rise of has_int seen by the DUT
            if (has_int && first_set < 0) begin
                first_set = k;
            end
            @(posedge clk);
            expire = m_count && (m_tval == 0);
            if (clr) begin
                m_pend = 1'b0;
            end else if (expire) begin
                m_pend = 1'b1;
            end
            if (m_count) begin
                m_count = timer_keeps_counting(m_tval, tcfg);
                m_tval  = timer_next_tval(m_tval, tcfg);
            end
            pend_age = m_pend ? pend_age + 1 : 0;
            clr = (pend_age == 2);
            csr_wr_en <= clr;
            csr_waddr <= csr_pkg::ADDR_TICLR;
            csr_wdata <= 32'h1;
        end
        compare("first expiry cycle", expiry_cycles(n), first_set);
        write_csr(csr_pkg::ADDR_TCFG, 32'h0);
        write_csr(csr_pkg::ADDR_TICLR, 32'h1);
        m_pend = 1'b0;
    endtask

    task automatic timers();
        int n;
        start_test();
        write_csr(csr_pkg::ADDR_ECFG, 32'h800);
        m_ecfg = 32'h800;
        write_csr(csr_pkg::ADDR_ESTAT, 32'h0);
        m_estat = apply_mask(m_estat, 32'h0, csr_pkg::MASK_ESTAT_SW);
        write_csr(csr_pkg::ADDR_CRMD, 32'hc);
        m_crmd = apply_mask(m_crmd, 32'hc, csr_pkg::MASK_CRMD);
        n = 1 + rand32() % N_MAX;
        timer_test(1'b0, n, expiry_cycles(n) + 6);
        end_test("timer_oneshot");
        start_test();
        n = 1 + rand32() % N_MAX;
        timer_test(1'b1, n, 3 * expiry_cycles(n) + 2);
        end_test("timer_periodic");
    endtask

    task automatic interrupt_test();
        logic [31:0] r;
        start_test();
        for (int i = 0; i < N_ITER; i++) begin
            r = rand32();
            write_csr(csr_pkg::ADDR_ECFG, r);
            m_ecfg = apply_mask(m_ecfg, r, csr_pkg::MASK_ECFG);
            r = rand32();
            write_csr(csr_pkg::ADDR_ESTAT, r);
            m_estat = apply_mask(m_estat, r, csr_pkg::MASK_ESTAT_SW);
            write_csr(csr_pkg::ADDR_CRMD, 32'h8 | {29'h0, r[9], 2'b00});
            m_crmd = apply_mask(m_crmd, 32'h8 | {29'h0, r[9], 2'b00}, csr_pkg::MASK_CRMD);
            @(posedge clk);
            interrupt <= r[23:16];
            @(posedge clk);
            m_hw = r[23:16];
            @(negedge clk);
            compare("has_int", {31'h0, int_pending(m_ecfg, estat_view(), m_crmd[2])},
                    {31'h0, has_int});
        end
        end_test("interrupt");
    endtask

    initial begin
        reset       = 1'b1;
        csr_raddr   = '0;
        csr_wr_en   = 1'b0;
        csr_waddr   = '0;
        csr_wdata   = '0;
        excp_flush  = 1'b0;
        era_in      = '0;
        ecode_in    = '0;
        esubcode_in = '0;
        ertn_flush  = 1'b0;
        interrupt   = '0;
        for (int i = 0; i < 5; i++) begin
            m_scratch[i] = '0;
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        start_test();
        read_check(csr_pkg::ADDR_CRMD, 32'h8, "csr_rdata");
        compare("has_int", 32'h0, {31'h0, has_int});
        end_test("reset");
        scratch_test();
        mask_test();
        exception_test();
        timers();
        interrupt_test();
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: hdl/csr_top.sv
`timescale 1ns/1ps

module csr_top (
    input  logic                  clk,
    input  logic                  reset,
    input  csr_pkg::csr_addr_t    csr_raddr,
    output csr_pkg::csr_data_t    csr_rdata,
    input  logic                  csr_wr_en,
    input  csr_pkg::csr_addr_t    csr_waddr,
    input  csr_pkg::csr_data_t    csr_wdata,
    input  logic                  excp_flush,
    input  csr_pkg::csr_data_t    era_in,
    input  csr_pkg::ecode_t       ecode_in,
    input  csr_pkg::esubcode_t    esubcode_in,
    input  logic                  ertn_flush,
    input  csr_pkg::hw_int_t      interrupt,
    output csr_pkg::csr_data_t    eentry_out,
    output csr_pkg::csr_data_t    era_out,
    output csr_pkg::plv_t         plv_out,
    output csr_pkg::csr_data_t    tid_out,
    output logic                  has_int
);

    csr_pkg::csr_sel_t  wr_sel;
    csr_pkg::csr_sel_t  rd_sel;
    logic               rd_bypass;
    logic               timer_int;
    csr_pkg::csr_data_t crmd, prmd, ecfg, estat, era, eentry;
    csr_pkg::csr_data_t save0, save1, save2, save3, tid;
    csr_pkg::csr_data_t tcfg, tval;

    csr_addr_decode u_decode (
        .csr_raddr (csr_raddr),
        .csr_waddr (csr_waddr),
        .csr_wr_en (csr_wr_en),
        .wr_sel    (wr_sel),
        .rd_sel    (rd_sel),
        .rd_bypass (rd_bypass)
    );

    csr_exception_regs u_excp (
        .clk         (clk),
        .reset       (reset),
        .wr_sel      (wr_sel),
        .csr_wdata   (csr_wdata),
        .excp_flush  (excp_flush),
        .ertn_flush  (ertn_flush),
        .era_in      (era_in),
        .ecode_in    (ecode_in),
        .esubcode_in (esubcode_in),
        .interrupt   (interrupt),
        .timer_int   (timer_int),
        .crmd        (crmd),
        .prmd        (prmd),
        .ecfg        (ecfg),
        .estat       (estat),
        .era         (era),
        .eentry      (eentry),
        .plv_out     (plv_out),
        .has_int     (has_int)
    );

    csr_timer u_timer (
        .clk       (clk),
        .reset     (reset),
        .wr_sel    (wr_sel),
        .csr_wdata (csr_wdata),
        .tcfg      (tcfg),
        .tval      (tval),
        .timer_int (timer_int)
    );

    csr_scratch_regs u_scratch (
        .clk       (clk),
        .reset     (reset),
        .wr_sel    (wr_sel),
        .csr_wdata (csr_wdata),
        .save0     (save0),
        .save1     (save1),
        .save2     (save2),
        .save3     (save3),
        .tid       (tid)
    );

    csr_read_mux u_read_mux (
        .rd_sel    (rd_sel),
        .rd_bypass (rd_bypass),
        .csr_wdata (csr_wdata),
        .crmd      (crmd),
        .prmd      (prmd),
        .ecfg      (ecfg),
        .estat     (estat),
        .era       (era),
        .eentry    (eentry),
        .save0     (save0),
        .save1     (save1),
        .save2     (save2),
        .save3     (save3),
        .tid       (tid),
        .tcfg      (tcfg),
        .tval      (tval),
        .csr_rdata (csr_rdata)
    );

    assign eentry_out = eentry;
    assign era_out    = era;
    assign tid_out    = tid;

endmodule

// File: hdl/csr_read_mux.sv
`timescale 1ns/1ps

module csr_read_mux (
    input  csr_pkg::csr_sel_t  rd_sel,
    input  logic               rd_bypass,
    input  csr_pkg::csr_data_t csr_wdata,
    input  csr_pkg::csr_data_t crmd,
    input  csr_pkg::csr_data_t prmd,
    input  csr_pkg::csr_data_t ecfg,
    input  csr_pkg::csr_data_t estat,
    input  csr_pkg::csr_data_t era,
    input  csr_pkg::csr_data_t eentry,
    input  csr_pkg::csr_data_t save0,
    input  csr_pkg::csr_data_t save1,
    input  csr_pkg::csr_data_t save2,
    input  csr_pkg::csr_data_t save3,
    input  csr_pkg::csr_data_t tid,
    input  csr_pkg::csr_data_t tcfg,
    input  csr_pkg::csr_data_t tval,
    output csr_pkg::csr_data_t csr_rdata
);

    csr_pkg::csr_data_t regs [csr_pkg::NUM_SEL];

    always_comb begin
        regs[csr_pkg::SEL_CRMD]   = crmd;
        regs[csr_pkg::SEL_PRMD]   = prmd;
        regs[csr_pkg::SEL_ECFG]   = ecfg;
        regs[csr_pkg::SEL_ESTAT]  = estat;
        regs[csr_pkg::SEL_ERA]    = era;
        regs[csr_pkg::SEL_EENTRY] = eentry;
        regs[csr_pkg::SEL_SAVE0]  = save0;
        regs[csr_pkg::SEL_SAVE1]  = save1;
        regs[csr_pkg::SEL_SAVE2]  = save2;
        regs[csr_pkg::SEL_SAVE3]  = save3;
        regs[csr_pkg::SEL_TID]    = tid;
        regs[csr_pkg::SEL_TCFG]   = tcfg;
        regs[csr_pkg::SEL_TVAL]   = tval;
        // write-only clear register
        regs[csr_pkg::SEL_TICLR]  = '0;
    end

    always_comb begin
        csr_rdata = '0;
        for (int i = 0; i < csr_pkg::NUM_SEL; i++) begin
            csr_rdata = csr_rdata | ({32{rd_sel[i]}} & regs[i]);
        end
        if (rd_bypass) begin
            csr_rdata = csr_wdata;
        end
    end

endmodule

// File: hdl/csr_scratch_regs.sv
`timescale 1ns/1ps

module csr_scratch_regs (
    input  logic               clk,
    input  logic               reset,
    input  csr_pkg::csr_sel_t  wr_sel,
    input  csr_pkg::csr_data_t csr_wdata,
    output csr_pkg::csr_data_t save0,
    output csr_pkg::csr_data_t save1,
    output csr_pkg::csr_data_t save2,
    output csr_pkg::csr_data_t save3,
    output csr_pkg::csr_data_t tid
);

    localparam int NUM_SCRATCH = 5;

    // save0..save3 then tid, same order as the selects
    csr_pkg::csr_data_t scratch [NUM_SCRATCH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_SCRATCH; i++) begin
                scratch[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_SCRATCH; i++) begin
                if (wr_sel[csr_pkg::SEL_SAVE0 + i]) begin
                    scratch[i] <= csr_wdata;
                end
            end
        end
    end

    assign save0 = scratch[0];
    assign save1 = scratch[1];
    assign save2 = scratch[2];
    assign save3 = scratch[3];
    assign tid   = scratch[4];

endmodule

// File: hdl/csr_timer.sv
`timescale 1ns/1ps

module csr_timer (
    input  logic               clk,
    input  logic               reset,
    input  csr_pkg::csr_sel_t  wr_sel,
    input  csr_pkg::csr_data_t csr_wdata,
    output csr_pkg::csr_data_t tcfg,
    output csr_pkg::csr_data_t tval,
    output logic               timer_int
);

    csr_pkg::timer_state_t state;
    csr_pkg::csr_data_t    tcfg_wr_val;
    logic                  tcfg_we;
    logic                  ticlr_clr;
    logic                  expire;

    assign tcfg_we     = wr_sel[csr_pkg::SEL_TCFG];
    assign ticlr_clr   = wr_sel[csr_pkg::SEL_TICLR] && csr_wdata[csr_pkg::BIT_TICLR_CLR];
    assign tcfg_wr_val = csr_wdata & csr_pkg::MASK_TCFG;
    assign expire      = (state == csr_pkg::TIMER_COUNT) && (tval == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= csr_pkg::TIMER_IDLE;
            tcfg  <= '0;
            tval  <= '0;
        end else if (tcfg_we) begin
            tcfg <= tcfg_wr_val;
            tval <= {tcfg_wr_val[csr_pkg::INITVAL_HI:csr_pkg::INITVAL_LO], 2'b00};
            state <= tcfg_wr_val[csr_pkg::BIT_TCFG_EN] ? csr_pkg::TIMER_COUNT
                                                       : csr_pkg::TIMER_IDLE;
        end else if (state == csr_pkg::TIMER_COUNT) begin
            if (tval != '0) begin
                tval <= tval - 32'd1;
            end else if (tcfg[csr_pkg::BIT_TCFG_PERIODIC]) begin
                tval <= {tcfg[csr_pkg::INITVAL_HI:csr_pkg::INITVAL_LO], 2'b00};
            end else begin
                // one-shot done
                tval  <= '1;
                state <= csr_pkg::TIMER_IDLE;
            end
        end
    end

    // clear > tcfg write > expiry
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (ticlr_clr) begin
            timer_int <= 1'b0;
        end else if (!tcfg_we && expire) begin
            timer_int <= 1'b1;
        end
    end

endmodule

// File: hdl/csr_exception_regs.sv
`timescale 1ns/1ps

module csr_exception_regs (
    input  logic                  clk,
    input  logic                  reset,
    input  csr_pkg::csr_sel_t     wr_sel,
    input  csr_pkg::csr_data_t    csr_wdata,
    input  logic                  excp_flush,
    input  logic                  ertn_flush,
    input  csr_pkg::csr_data_t    era_in,
    input  csr_pkg::ecode_t       ecode_in,
    input  csr_pkg::esubcode_t    esubcode_in,
    input  csr_pkg::hw_int_t      interrupt,
    input  logic                  timer_int,
    output csr_pkg::csr_data_t    crmd,
    output csr_pkg::csr_data_t    prmd,
    output csr_pkg::csr_data_t    ecfg,
    output csr_pkg::csr_data_t    estat,
    output csr_pkg::csr_data_t    era,
    output csr_pkg::csr_data_t    eentry,
    output csr_pkg::plv_t         plv_out,
    output logic                  has_int
);

    csr_pkg::csr_data_t estat_q;

    function automatic csr_pkg::csr_data_t merge(
        input csr_pkg::csr_data_t old_val,
        input csr_pkg::csr_data_t new_val,
        input csr_pkg::csr_data_t mask
    );
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    // flush > ertn > write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd <= csr_pkg::CRMD_RESET;
        end else if (excp_flush) begin
            crmd[csr_pkg::PLV_HI:csr_pkg::PLV_LO] <= '0;
            crmd[csr_pkg::BIT_IE]                 <= 1'b0;
        end else if (ertn_flush) begin
            crmd[csr_pkg::PLV_HI:csr_pkg::PLV_LO] <= prmd[csr_pkg::PLV_HI:csr_pkg::PLV_LO];
            crmd[csr_pkg::BIT_IE]                 <= prmd[csr_pkg::BIT_IE];
        end else if (wr_sel[csr_pkg::SEL_CRMD]) begin
            crmd <= merge(crmd, csr_wdata, csr_pkg::MASK_CRMD);
        end
    end

    // pplv and pie share the plv/ie bit positions
    always_ff @(posedge clk) begin
        if (reset) begin
            prmd <= '0;
        end else if (excp_flush) begin
            prmd[csr_pkg::PLV_HI:csr_pkg::PLV_LO] <= crmd[csr_pkg::PLV_HI:csr_pkg::PLV_LO];
            prmd[csr_pkg::BIT_IE]                 <= crmd[csr_pkg::BIT_IE];
        end else if (wr_sel[csr_pkg::SEL_PRMD]) begin
            prmd <= merge(prmd, csr_wdata, csr_pkg::MASK_PRMD);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg <= '0;
        end else if (wr_sel[csr_pkg::SEL_ECFG]) begin
            ecfg <= merge(ecfg, csr_wdata, csr_pkg::MASK_ECFG);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            estat_q <= '0;
        end else begin
            if (excp_flush) begin
                estat_q[csr_pkg::ECODE_HI:csr_pkg::ECODE_LO]       <= ecode_in;
                estat_q[csr_pkg::ESUBCODE_HI:csr_pkg::ESUBCODE_LO] <= esubcode_in;
            end else if (wr_sel[csr_pkg::SEL_ESTAT]) begin
                estat_q <= merge(estat_q, csr_wdata, csr_pkg::MASK_ESTAT_SW);
            end
            // hardware lines sampled every cycle
            estat_q[csr_pkg::HWI_HI:csr_pkg::HWI_LO] <= interrupt;
        end
    end

    // timer pending bit lives in the timer block
    always_comb begin
        estat                  = estat_q;
        estat[csr_pkg::BIT_TI] = timer_int;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            era <= '0;
        end else if (excp_flush) begin
            era <= era_in;
        end else if (wr_sel[csr_pkg::SEL_ERA]) begin
            era <= csr_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            eentry <= '0;
        end else if (wr_sel[csr_pkg::SEL_EENTRY]) begin
            eentry <= merge(eentry, csr_wdata, csr_pkg::MASK_EENTRY);
        end
    end

    assign plv_out = crmd[csr_pkg::PLV_HI:csr_pkg::PLV_LO];

    assign has_int = (|(ecfg[csr_pkg::INT_HI:0] & estat[csr_pkg::INT_HI:0]))
                     && crmd[csr_pkg::BIT_IE];

endmodule

// File: hdl/csr_addr_decode.sv
`timescale 1ns/1ps

module csr_addr_decode (
    input  csr_pkg::csr_addr_t csr_raddr,
    input  csr_pkg::csr_addr_t csr_waddr,
    input  logic               csr_wr_en,
    output csr_pkg::csr_sel_t  wr_sel,
    output csr_pkg::csr_sel_t  rd_sel,
    output logic               rd_bypass
);

    function automatic csr_pkg::csr_sel_t addr_to_sel(input csr_pkg::csr_addr_t addr);
        csr_pkg::csr_sel_t sel;
        sel = '0;
        case (addr)
            csr_pkg::ADDR_CRMD:   sel[csr_pkg::SEL_CRMD]   = 1'b1;
            csr_pkg::ADDR_PRMD:   sel[csr_pkg::SEL_PRMD]   = 1'b1;
            csr_pkg::ADDR_ECFG:   sel[csr_pkg::SEL_ECFG]   = 1'b1;
            csr_pkg::ADDR_ESTAT:  sel[csr_pkg::SEL_ESTAT]  = 1'b1;
            csr_pkg::ADDR_ERA:    sel[csr_pkg::SEL_ERA]    = 1'b1;
            csr_pkg::ADDR_EENTRY: sel[csr_pkg::SEL_EENTRY] = 1'b1;
            csr_pkg::ADDR_SAVE0:  sel[csr_pkg::SEL_SAVE0]  = 1'b1;
            csr_pkg::ADDR_SAVE1:  sel[csr_pkg::SEL_SAVE1]  = 1'b1;
            csr_pkg::ADDR_SAVE2:  sel[csr_pkg::SEL_SAVE2]  = 1'b1;
            csr_pkg::ADDR_SAVE3:  sel[csr_pkg::SEL_SAVE3]  = 1'b1;
            csr_pkg::ADDR_TID:    sel[csr_pkg::SEL_TID]    = 1'b1;
            csr_pkg::ADDR_TCFG:   sel[csr_pkg::SEL_TCFG]   = 1'b1;
            csr_pkg::ADDR_TVAL:   sel[csr_pkg::SEL_TVAL]   = 1'b1;
            csr_pkg::ADDR_TICLR:  sel[csr_pkg::SEL_TICLR]  = 1'b1;
            // unmapped, no select
            default: ;
        endcase
        return sel;
    endfunction

    assign rd_sel = addr_to_sel(csr_raddr);
    assign wr_sel = csr_wr_en ? addr_to_sel(csr_waddr) : '0;

    // same-cycle write to the address being read
    assign rd_bypass = csr_wr_en && (csr_waddr == csr_raddr);

endmodule

// File: hdl/csr_pkg.sv
package csr_pkg;

    localparam int NUM_SEL = 14;

    typedef logic [13:0]        csr_addr_t;
    typedef logic [31:0]        csr_data_t;
    typedef logic [NUM_SEL-1:0] csr_sel_t;
    typedef logic [1:0]         plv_t;
    typedef logic [5:0]         ecode_t;
    typedef logic [8:0]         esubcode_t;
    typedef logic [7:0]         hw_int_t;

    typedef enum logic {
        TIMER_IDLE,
        TIMER_COUNT
    } timer_state_t;

    // register addresses
    localparam csr_addr_t ADDR_CRMD   = 14'h0;
    localparam csr_addr_t ADDR_PRMD   = 14'h1;
    localparam csr_addr_t ADDR_ECFG   = 14'h4;
    localparam csr_addr_t ADDR_ESTAT  = 14'h5;
    localparam csr_addr_t ADDR_ERA    = 14'h6;
    localparam csr_addr_t ADDR_EENTRY = 14'hc;
    localparam csr_addr_t ADDR_SAVE0  = 14'h30;
    localparam csr_addr_t ADDR_SAVE1  = 14'h31;
    localparam csr_addr_t ADDR_SAVE2  = 14'h32;
    localparam csr_addr_t ADDR_SAVE3  = 14'h33;
    localparam csr_addr_t ADDR_TID    = 14'h40;
    localparam csr_addr_t ADDR_TCFG   = 14'h41;
    localparam csr_addr_t ADDR_TVAL   = 14'h42;
    localparam csr_addr_t ADDR_TICLR  = 14'h44;

    // one-hot select positions, save0..tid kept contiguous
    localparam int SEL_CRMD   = 0;
    localparam int SEL_PRMD   = 1;
    localparam int SEL_ECFG   = 2;
    localparam int SEL_ESTAT  = 3;
    localparam int SEL_ERA    = 4;
    localparam int SEL_EENTRY = 5;
    localparam int SEL_SAVE0  = 6;
    localparam int SEL_SAVE1  = 7;
    localparam int SEL_SAVE2  = 8;
    localparam int SEL_SAVE3  = 9;
    localparam int SEL_TID    = 10;
    localparam int SEL_TCFG   = 11;
    localparam int SEL_TVAL   = 12;
    localparam int SEL_TICLR  = 13;

    // writable fields
    localparam csr_data_t MASK_CRMD     = 32'h0000_01ff;
    localparam csr_data_t MASK_PRMD     = 32'h0000_0007;
    localparam csr_data_t MASK_ECFG     = 32'h0000_1bff;
    localparam csr_data_t MASK_ESTAT_SW = 32'h0000_0003;
    localparam csr_data_t MASK_EENTRY   = 32'hffff_ffc0;
    localparam csr_data_t MASK_TCFG     = 32'hffff_ffff;

    localparam csr_data_t CRMD_RESET = 32'h0000_0008;

    localparam int PLV_HI            = 1;
    localparam int PLV_LO            = 0;
    localparam int BIT_IE            = 2;
    localparam int BIT_TI            = 11;
    localparam int INT_HI            = 12;
    localparam int BIT_TCFG_EN       = 0;
    localparam int BIT_TCFG_PERIODIC = 1;
    localparam int BIT_TICLR_CLR     = 0;
    localparam int INITVAL_HI        = 31;
    localparam int INITVAL_LO        = 2;
    localparam int ECODE_HI          = 21;
    localparam int ECODE_LO          = 16;
    localparam int ESUBCODE_HI       = 30;
    localparam int ESUBCODE_LO       = 22;
    localparam int HWI_HI            = 9;
    localparam int HWI_LO            = 2;

endpackage
